// File: tb.f
+incdir+include
logic/uartPkg.sv
logic/rxSampler.sv
logic/rxDeframer.sv
logic/txSerializer.sv
logic/uartTop.sv
test/uartTb.sv

// File: test/uartTb.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uartTb;
  import uartPkg::*;

  localparam int BitClks   = `CLKS_PER_BIT;
  localparam int FrameClks = 10 * `CLKS_PER_BIT;

  logic      r_Clock;
  logic      i_rstN;
  logic      i_rxSerial;
  logic      i_txValid;
  logic [7:0] i_txByte;
  logic      o_rxValid;
  rxResult_t o_rxResult;
  logic      o_txSerial;
  logic      o_txActive;
  logic      o_txDone;

  // Serial driver output and loopback select
  logic      rxDrive;
  logic      loopSel;
  integer    seed;
  int        rxCount;
  rxResult_t rxExpQ[$];

  always #5 r_Clock = ~r_Clock;

  // Receive line from driver or from own transmitter
  assign i_rxSerial = loopSel ? o_txSerial : rxDrive;

  uartTop UUT (
    .r_Clock    (r_Clock),
    .i_rstN     (i_rstN),
    .i_rxSerial (i_rxSerial),
    .o_rxValid  (o_rxValid),
    .o_rxResult (o_rxResult),
    .i_txValid  (i_txValid),
    .i_txByte   (i_txByte),
    .o_txSerial (o_txSerial),
    .o_txActive (o_txActive),
    .o_txDone   (o_txDone)
  );

  //////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic reportMismatch(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "Stopping at first mismatch");
  endtask

  task automatic reportTimeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display(">>> FAIL");
    $fatal(1, "Stopping on timeout");
  endtask

  // Stop value 0 means framing error
  function automatic rxResult_t expectedRx(input logic [7:0] data, input logic stopVal);
    rxResult_t res;
    res.data     = data;
    res.frameErr = ~stopVal;
    return res;
  endfunction

  task automatic checkRxResult(input rxResult_t obs, input rxResult_t exp);
    if (obs !== exp)
    begin
      reportMismatch($sformatf("rx data %02h err %0b, expected data %02h err %0b",
                               obs.data, obs.frameErr, exp.data, exp.frameErr));
    end
  endtask

  task automatic checkTxFrame(input logic [7:0] obsByte, input logic obsStop,
                              input logic [7:0] expByte, input logic expStop);
    if ((obsByte !== expByte) || (obsStop !== expStop))
    begin
      reportMismatch($sformatf("tx byte %02h stop %0b, expected byte %02h stop %0b",
                               obsByte, obsStop, expByte, expStop));
    end
  endtask

  task automatic checkFlag(input string what, input logic obs, input logic exp);
    if (obs !== exp)
    begin
      reportMismatch($sformatf("%s is %0b, expected %0b", what, obs, exp));
    end
  endtask

  // Every receive result checked against the oldest expected frame
  always @(negedge r_Clock)
  begin
    if (i_rstN && o_rxValid)
    begin
      if (rxExpQ.size() == 0)
      begin
        reportMismatch("o_rxValid with no frame sent");
      end
      else
      begin
        checkRxResult(o_rxResult, rxExpQ.pop_front());
        rxCount++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Serial driver, monitor and waits
  //////////////////////////////////////////////////

  // Start, 8 data bits LSB first, stop, then one idle bit
  task automatic sendFrame(input logic [7:0] data, input logic stopVal);
    @(negedge r_Clock);
    rxDrive = 1'b0;
    repeat (BitClks) @(negedge r_Clock);
    for (int i = 0; i < 8; i++)
    begin
      rxDrive = data[i];
      repeat (BitClks) @(negedge r_Clock);
    end
    rxDrive = stopVal;
    repeat (BitClks) @(negedge r_Clock);
    // Idle gap so a low stop bit is not merged with the next start
    rxDrive = 1'b1;
    repeat (BitClks) @(negedge r_Clock);
  endtask

  task automatic requestTx(input logic [7:0] data);
    @(negedge r_Clock);
    i_txValid = 1'b1;
    i_txByte  = data;
    @(negedge r_Clock);
    i_txValid = 1'b0;
  endtask

  // Rebuilds one frame from o_txSerial sampled at each bit middle
  task automatic readTxFrame(output logic [7:0] data, output logic stopVal,
                             output logic activeOk);
    int cnt;
    cnt      = 0;
    activeOk = 1'b1;
    @(negedge r_Clock);
    while (o_txSerial !== 1'b0)
    begin
      cnt++;
      if (cnt > 2 * BitClks)
      begin
        reportTimeout("start bit on o_txSerial");
      end
      @(negedge r_Clock);
    end
    repeat (BitClks / 2) @(negedge r_Clock);
    checkFlag("o_txSerial at mid start bit", o_txSerial, 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (BitClks) @(negedge r_Clock);
      data[i] = o_txSerial;
      activeOk = activeOk & o_txActive;
    end
    repeat (BitClks) @(negedge r_Clock);
    stopVal  = o_txSerial;
    activeOk = activeOk & o_txActive;
  endtask

  task automatic waitRxCount(input int target);
    int cnt;
    cnt = 0;
    @(negedge r_Clock);
    while (rxCount < target)
    begin
      cnt++;
      if (cnt > 2 * FrameClks)
      begin
        reportTimeout("o_rxValid");
      end
      @(negedge r_Clock);
    end
  endtask

  task automatic waitTxDone();
    int cnt;
    cnt = 0;
    @(negedge r_Clock);
    while (o_txDone !== 1'b1)
    begin
      cnt++;
      if (cnt > 2 * BitClks)
      begin
        reportTimeout("o_txDone");
      end
      @(negedge r_Clock);
    end
  endtask

  task automatic waitTxActive();
    int cnt;
    cnt = 0;
    while (o_txActive !== 1'b1)
    begin
      cnt++;
      if (cnt > BitClks)
      begin
        reportTimeout("o_txActive");
      end
      @(negedge r_Clock);
    end
  endtask

  // Counts done pulses and low line after done over a fixed window
  task automatic countTxDone(input int cycles, output int nDone, output int lowAfter);
    nDone    = 0;
    lowAfter = 0;
    repeat (cycles)
    begin
      @(negedge r_Clock);
      if (o_txDone)
      begin
        nDone++;
      end
      else if ((nDone > 0) && !o_txSerial)
      begin
        lowAfter++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    logic [7:0] txData;
    logic       txStop;
    logic       activeOk;
    logic [7:0] randByte;
    int         nDone;
    int         lowAfter;
    r_Clock    = 1'b0;
    i_rstN     = 1'b0;
    i_txValid  = 1'b0;
    i_txByte   = 8'h00;
    rxDrive    = 1'b1;
    loopSel    = 1'b0;
    seed       = 47;
    rxCount    = 0;
    repeat (4) @(posedge r_Clock);
    @(negedge r_Clock);
    i_rstN = 1'b1;
    repeat (4) @(negedge r_Clock);
    checkFlag("o_txSerial after reset", o_txSerial, 1'b1);
    checkFlag("o_txActive after reset", o_txActive, 1'b0);
    checkFlag("o_txDone after reset", o_txDone, 1'b0);
    checkRxResult(o_rxResult, '0);

    // Transmit 0xAB
    fork
      requestTx(8'hAB);
      readTxFrame(txData, txStop, activeOk);
    join
    waitTxDone();
    checkTxFrame(txData, txStop, 8'hAB, 1'b1);
    checkFlag("o_txActive during frame", activeOk, 1'b1);

    // Receive 0x3F with a good stop bit
    rxExpQ.push_back(expectedRx(8'h3F, 1'b1));
    fork
      sendFrame(8'h3F, 1'b1);
      waitRxCount(rxCount + 1);
    join

    // Loopback with random bytes
    @(negedge r_Clock);
    loopSel = 1'b1;
    for (int n = 0; n < 20; n++)
    begin
      randByte = $random(seed);
      rxExpQ.push_back(expectedRx(randByte, 1'b1));
      fork
        requestTx(randByte);
        readTxFrame(txData, txStop, activeOk);
        waitRxCount(rxCount + 1);
      join
      waitTxDone();
      checkTxFrame(txData, txStop, randByte, 1'b1);
    end
    @(negedge r_Clock);
    loopSel = 1'b0;

    // Framing error then a clean frame
    rxExpQ.push_back(expectedRx(8'h96, 1'b0));
    fork
      sendFrame(8'h96, 1'b0);
      waitRxCount(rxCount + 1);
    join
    rxExpQ.push_back(expectedRx(8'h69, 1'b1));
    fork
      sendFrame(8'h69, 1'b1);
      waitRxCount(rxCount + 1);
    join

    // Short low pulse must not start a frame
    @(negedge r_Clock);
    rxDrive = 1'b0;
    repeat (BitClks / 4) @(negedge r_Clock);
    rxDrive = 1'b1;
    repeat (2 * FrameClks)
    begin
      @(negedge r_Clock);
      checkFlag("o_rxValid after glitch", o_rxValid, 1'b0);
    end

    // Second request while busy is dropped
    fork
      begin
        requestTx(8'hC5);
        waitTxActive();
        @(negedge r_Clock);
        i_txValid = 1'b1;
        i_txByte  = 8'h5A;
        @(negedge r_Clock);
        i_txValid = 1'b0;
      end
      readTxFrame(txData, txStop, activeOk);
      countTxDone(14 * BitClks, nDone, lowAfter);
    join
    checkTxFrame(txData, txStop, 8'hC5, 1'b1);
    checkFlag("single o_txDone pulse", nDone == 1, 1'b1);
    checkFlag("line idle after o_txDone", lowAfter == 0, 1'b1);

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: logic/uartTop.sv
`timescale 1ns/1ps

module uartTop (
  input  logic               r_Clock,
  input  logic               i_rstN,
  // Receive side
  input  logic               i_rxSerial,
  output logic               o_rxValid,
  output uartPkg::rxResult_t o_rxResult,
  // Transmit side
  input  logic               i_txValid,
  input  logic [7:0]         i_txByte,
  output logic               o_txSerial,
  output logic               o_txActive,
  output logic               o_txDone
);
  import uartPkg::*;

  // Sampled bits between the two receive stages
  rxBit_t rxBit;

  //////////////////////////////////////////////////
  // Receive pipeline
  //////////////////////////////////////////////////

  // Sync, start detect and mid-bit sampling
  rxSampler rxSamplerInst (
    .r_Clock    (r_Clock),
    .i_rstN     (i_rstN),
    .i_rxSerial (i_rxSerial),
    .o_rxBit    (rxBit)
  );

  // Byte build and stop check
  rxDeframer rxDeframerInst (
    .r_Clock    (r_Clock),
    .i_rstN     (i_rstN),
    .i_rxBit    (rxBit),
    .o_rxValid  (o_rxValid),
    .o_rxResult (o_rxResult)
  );

  //////////////////////////////////////////////////
  // Transmit path
  //////////////////////////////////////////////////

  txSerializer txSerializerInst (
    .r_Clock    (r_Clock),
    .i_rstN     (i_rstN),
    .i_txValid  (i_txValid),
    .i_txByte   (i_txByte),
    .o_txSerial (o_txSerial),
    .o_txActive (o_txActive),
    .o_txDone   (o_txDone)
  );

endmodule

// File: logic/txSerializer.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module txSerializer (
  input  logic       r_Clock,
  input  logic       i_rstN,
  input  logic       i_txValid,
  input  logic [7:0] i_txByte,
  output logic       o_txSerial,
  output logic       o_txActive,
  output logic       o_txDone
);
  import uartPkg::*;

  // Counter end points
  localparam int unsigned FullCnt = `CLKS_PER_BIT - 1;
  localparam int unsigned IdxCnt  = `DATA_BITS - 1;
  localparam logic [`CLK_CNT_W-1:0] FullLast = FullCnt[`CLK_CNT_W-1:0];
  localparam logic [`BIT_IDX_W-1:0] IdxLast  = IdxCnt[`BIT_IDX_W-1:0];

  txState_t              state;
  logic [`CLK_CNT_W-1:0] clkCnt;
  logic [`BIT_IDX_W-1:0] bitIdx;
  logic [`DATA_BITS-1:0] txShift;
  logic                  bitEnd;
  logic                  capture;
  logic                  shiftNext;

  // Last cycle of the current bit period
  assign bitEnd    = (clkCnt == FullLast);
  // Requests only count in idle
  assign capture   = (state == TX_IDLE) && i_txValid;
  // Move to the next data bit
  assign shiftNext = (state == TX_DATA) && bitEnd && (bitIdx != IdxLast);

  //////////////////////////////////////////////////
  // Data byte holding register
  //////////////////////////////////////////////////

  // Bit 0 is always the next data bit to go out
  always_ff @(posedge r_Clock)
  begin
    if (capture)
    begin
      txShift <= i_txByte;
    end
    else if (shiftNext)
    begin
      txShift <= txShift >> 1;
    end
  end

  //////////////////////////////////////////////////
  // Frame sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge r_Clock or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      state      <= TX_IDLE;
      clkCnt     <= '0;
      bitIdx     <= '0;
      o_txSerial <= 1'b1;
      o_txActive <= 1'b0;
      o_txDone   <= 1'b0;
    end
    else
    begin
      o_txDone <= 1'b0;
      case (state)
        TX_IDLE:
        begin
          o_txSerial <= 1'b1;
          clkCnt     <= '0;
          bitIdx     <= '0;
          if (capture)
          begin
            // Start bit goes out on the next cycle
            o_txSerial <= 1'b0;
            o_txActive <= 1'b1;
            state      <= TX_START;
          end
        end
        TX_START:
        begin
          if (bitEnd)
          begin
            clkCnt     <= '0;
            o_txSerial <= txShift[0];
            state      <= TX_DATA;
          end
          else
          begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        TX_DATA:
        begin
          if (bitEnd)
          begin
            clkCnt <= '0;
            if (bitIdx == IdxLast)
            begin
              // Stop bit high
              o_txSerial <= 1'b1;
              state      <= TX_STOP;
            end
            else
            begin
              // Bit 1 becomes bit 0 on this same edge
              o_txSerial <= txShift[1];
              bitIdx     <= bitIdx + 1'b1;
            end
          end
          else
          begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        TX_STOP:
        begin
          if (bitEnd)
          begin
            clkCnt     <= '0;
            o_txActive <= 1'b0;
            o_txDone   <= 1'b1;
            state      <= TX_DONE;
          end
          else
          begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        TX_DONE:
        begin
          // One cycle for the done pulse then ready again
          state <= TX_IDLE;
        end
        default:
        begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/rxDeframer.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module rxDeframer (
  input  logic               r_Clock,
  input  logic               i_rstN,
  input  uartPkg::rxBit_t    i_rxBit,
  output logic               o_rxValid,
  output uartPkg::rxResult_t o_rxResult
);
  import uartPkg::*;

  logic                  startHit;
  logic                  dataHit;
  logic                  stopHit;
  logic [`DATA_BITS-1:0] shiftReg;

  //////////////////////////////////////////////////
  // Strobe decode
  //////////////////////////////////////////////////

  // Kind only counts while the strobe is up
  assign startHit = i_rxBit.strobe && (i_rxBit.kind == START_BIT);
  assign dataHit  = i_rxBit.strobe && (i_rxBit.kind == DATA_BIT);
  assign stopHit  = i_rxBit.strobe && (i_rxBit.kind == STOP_BIT);

  //////////////////////////////////////////////////
  // Byte assembly
  //////////////////////////////////////////////////

  // LSB arrives first
  // Shifting in from the top lands it at bit 0 after all data bits
  always_ff @(posedge r_Clock)
  begin
    if (startHit)
    begin
      // Fresh frame
      shiftReg <= '0;
    end
    else if (dataHit)
    begin
      shiftReg <= {i_rxBit.value, shiftReg[`DATA_BITS-1:1]};
    end
  end

  //////////////////////////////////////////////////
  // Frame result
  //////////////////////////////////////////////////

  // Result registered on the stop strobe
  // Valid pulse one cycle after that strobe
  always_ff @(posedge r_Clock or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      o_rxValid  <= 1'b0;
      o_rxResult <= '0;
    end
    else
    begin
      o_rxValid <= 1'b0;
      if (stopHit)
      begin
        o_rxValid <= 1'b1;
        // Stop bit must be high
        // A low one marks a framing error
        o_rxResult <= '{data: shiftReg, frameErr: ~i_rxBit.value};
      end
    end
  end

  // Result holds between frames
  // Nothing here stalls the sampler

endmodule

// File: logic/rxSampler.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module rxSampler (
  input  logic            r_Clock,
  input  logic            i_rstN,
  input  logic            i_rxSerial,
  output uartPkg::rxBit_t o_rxBit
);
  import uartPkg::*;

  // Counter end points
  localparam int unsigned HalfCnt = `CLKS_PER_BIT / 2 - 1;
  localparam int unsigned FullCnt = `CLKS_PER_BIT - 1;
  localparam int unsigned IdxCnt  = `DATA_BITS - 1;
  localparam logic [`CLK_CNT_W-1:0] HalfLast = HalfCnt[`CLK_CNT_W-1:0];
  localparam logic [`CLK_CNT_W-1:0] FullLast = FullCnt[`CLK_CNT_W-1:0];
  localparam logic [`BIT_IDX_W-1:0] IdxLast  = IdxCnt[`BIT_IDX_W-1:0];

  logic                  rxMeta;
  logic                  rxSync;
  logic                  rxPrev;
  logic                  fallEdge;
  logic                  bitEnd;
  rxState_t              state;
  logic [`CLK_CNT_W-1:0] clkCnt;
  logic [`BIT_IDX_W-1:0] bitIdx;

  //////////////////////////////////////////////////
  // Line synchronizer
  //////////////////////////////////////////////////

  // Idle line is high so flops come out of reset at 1
  always_ff @(posedge r_Clock or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end
    else
    begin
      rxMeta <= i_rxSerial;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  // High to low on the synced line
  assign fallEdge = rxPrev & ~rxSync;
  // Last cycle of a full bit period
  assign bitEnd   = (clkCnt == FullLast);

  //////////////////////////////////////////////////
  // Start detect and mid-bit sampling
  //////////////////////////////////////////////////

  always_ff @(posedge r_Clock or negedge i_rstN)
  begin
    if (!i_rstN)
    begin
      state   <= RX_IDLE;
      clkCnt  <= '0;
      bitIdx  <= '0;
      o_rxBit <= '0;
    end
    else
    begin
      // Strobe is a single cycle pulse
      o_rxBit.strobe <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          clkCnt <= '0;
          bitIdx <= '0;
          if (fallEdge)
          begin
            state <= RX_START;
          end
        end
        RX_START:
        begin
          if (clkCnt == HalfLast)
          begin
            clkCnt <= '0;
            // Still low at mid start bit so a real frame
            if (!rxSync)
            begin
              o_rxBit <= '{strobe: 1'b1, kind: START_BIT, value: rxSync};
              state   <= RX_DATA;
            end
            // High again means a glitch with no strobe
            else
            begin
              state <= RX_IDLE;
            end
          end
          else
          begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        RX_DATA:
        begin
          if (bitEnd)
          begin
            clkCnt  <= '0;
            o_rxBit <= '{strobe: 1'b1, kind: DATA_BIT, value: rxSync};
            if (bitIdx == IdxLast)
            begin
              state <= RX_STOP;
            end
            else
            begin
              bitIdx <= bitIdx + 1'b1;
            end
          end
          else
          begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        RX_STOP:
        begin
          if (bitEnd)
          begin
            clkCnt  <= '0;
            o_rxBit <= '{strobe: 1'b1, kind: STOP_BIT, value: rxSync};
            // Back to idle at mid stop bit
            state   <= RX_IDLE;
          end
          else
          begin
            clkCnt <= clkCnt + 1'b1;
          end
        end
        default:
        begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

// File: logic/uartPkg.sv
`include "uart_params.svh"

package uartPkg;

  //////////////////////////////////////////////////
  // State encodings
  //////////////////////////////////////////////////

  // Receive sampler states
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rxState_t;

  // Transmit serializer states
  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP,
    TX_DONE
  } txState_t;

  // Which part of the frame a sample came from
  typedef enum logic [1:0] {
    START_BIT,
    DATA_BIT,
    STOP_BIT
  } bitKind_t;

  //////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////

  // One sampled bit from sampler to deframer
  // Kind and value only meaningful with strobe high
  typedef struct packed {
    logic     strobe;
    bitKind_t kind;
    logic     value;
  } rxBit_t;

  // Received byte plus stop bit check
  typedef struct packed {
    logic [`DATA_BITS-1:0] data;
    logic                  frameErr;
  } rxResult_t;

endpackage

// File: include/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Serial timing
// 10 MHz system clock into 115200 baud
`define CLKS_PER_BIT 87

// Data bits per frame
// One start bit and one stop bit wrap these on the line
`define DATA_BITS 8

// Width of the per-bit clock counter
// Holds every count up to CLKS_PER_BIT minus one
`define CLK_CNT_W ($clog2(`CLKS_PER_BIT))

// Width of the data bit index
// Holds every index up to DATA_BITS minus one
`define BIT_IDX_W ($clog2(`DATA_BITS))

`endif
